// ==== rtl/busPkg.sv ====
`default_nettype none

package busPkg;

  typedef enum logic [1:0] {
    MemIdle  = 2'd0,
    MemReady = 2'd1,  // Single cycle, read data valid
    MemError = 2'd2
  } memStatusT;

  typedef struct packed {
    logic        read;   // One cycle strobe
    logic        write;  // One cycle strobe
    logic [31:0] address;
    logic [31:0] writeData;
  } memReqT;

  typedef struct packed {
    memStatusT   status;
    logic [31:0] readData;
  } memRspT;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apbReqT;

  // Config register offsets
  localparam logic [7:0] RegCtrl    = 8'h00;
  localparam logic [7:0] RegStart   = 8'h04;
  localparam logic [7:0] RegStatus  = 8'h08;
  localparam logic [7:0] RegErrData = 8'h0c;
  localparam logic [7:0] RegIp      = 8'h10;
  localparam logic [7:0] RegDbgSel  = 8'h14;
  localparam logic [7:0] RegDbgData = 8'h18;

endpackage

`default_nettype wire

// ==== rtl/cpuControlRegs.sv ====
`default_nettype none

module cpuControlRegs #(
  parameter int RegCount = 16
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire busPkg::apbReqT         apbReq,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        start,
  output logic [31:0]                 startAddress,
  input  wire                         running,
  input  wire                         halted,
  input  wire isaPkg::haltCodeT       haltCode,
  input  wire [31:0]                  haltData,
  input  wire [31:0]                  ipointer,
  output logic [$clog2(RegCount)-1:0] dbgIndex,
  input  wire [31:0]                  dbgValue
);

  localparam int IdxW = $clog2(RegCount);
  localparam int StatusPad = 30 - $bits(isaPkg::haltCodeT);

  logic            runBit;
  logic            haltedQ;  // For halt rising edge
  logic            accessPhase, wrAccess;
  logic            mapped, readOnly;

  assign accessPhase = apbReq.psel && apbReq.penable;
  assign wrAccess = accessPhase && apbReq.pwrite && mapped && !readOnly;
  assign pready = 1'b1;  // No wait states
  assign pslverr = accessPhase && (!mapped || (apbReq.pwrite && readOnly));

  // Read mux, live values at the access phase
  always_comb begin
    mapped = 1'b1;
    readOnly = 1'b0;
    prdata = '0;
    case (apbReq.paddr)
      busPkg::RegCtrl:  prdata = {31'b0, runBit};
      busPkg::RegStart: prdata = startAddress;
      busPkg::RegStatus: begin
        prdata = {{StatusPad{1'b0}}, haltCode, halted, running};
        readOnly = 1'b1;
      end
      busPkg::RegErrData: begin
        prdata = haltData;
        readOnly = 1'b1;
      end
      busPkg::RegIp: begin
        prdata = ipointer;
        readOnly = 1'b1;
      end
      busPkg::RegDbgSel: prdata = {{(32 - IdxW){1'b0}}, dbgIndex};
      busPkg::RegDbgData: begin
        prdata = dbgValue;  // Register picked by the selector
        readOnly = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      runBit <= 1'b0;
      haltedQ <= 1'b0;
      start <= 1'b0;
      startAddress <= '0;
      dbgIndex <= '0;
    end else begin
      haltedQ <= halted;
      start <= 1'b0;
      if (halted && !haltedQ) runBit <= 1'b0;  // Core stopped itself
      if (wrAccess) begin
        case (apbReq.paddr)
          busPkg::RegCtrl: begin
            runBit <= apbReq.pwdata[0];
            start <= apbReq.pwdata[0] && !running;  // Only launch an idle core
          end
          busPkg::RegStart:  startAddress <= {apbReq.pwdata[31:2], 2'b00};  // Word aligned
          busPkg::RegDbgSel: dbgIndex <= apbReq.pwdata[IdxW-1:0];
          default: ;
        endcase
      end
    end
  end

  startSinglePulse: assert property (@(posedge clk) disable iff (reset) start |=> !start);

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
`default_nettype none

module cpuCore #(
  parameter int RegCount = 16  // Power of two, 4 to 64
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire busPkg::apbReqT     apbReq,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output busPkg::memReqT          memReq,
  input  wire busPkg::memRspT     memRsp
);

  localparam int IdxW = $clog2(RegCount);

  logic                         start, running, halted;
  logic [31:0]                  startAddress, haltData, ipointer;
  isaPkg::haltCodeT             haltCode;
  logic [IdxW-1:0]              rdIndexA, rdIndexB, rdIndexC;
  logic [IdxW-1:0]              wrIndex, dbgIndex;
  logic [31:0]                  operandA, operandB, operandC, flags;
  logic [31:0]                  wrData, flagsWrData, dbgValue;
  logic                         wrEnable, flagsWrEnable, branchTaken;
  isaPkg::opcodeT               opcode;
  logic [31:0]                  dataWord, result;
  logic [isaPkg::FlagCount-1:0] newFlags;

  // APB config beside the sequencer
  cpuControlRegs #(.RegCount(RegCount)) cpuControlRegs_i (
    .clk, .reset, .apbReq, .prdata, .pready, .pslverr, .start, .startAddress,
    .running, .halted, .haltCode, .haltData, .ipointer, .dbgIndex, .dbgValue
  );

  instrSequencer #(.RegCount(RegCount)) instrSequencer_i (
    .clk, .reset, .start, .startAddress, .memReq, .memRsp,
    .rdIndexA, .rdIndexB, .rdIndexC, .operandA, .operandB, .operandC, .flags,
    .wrEnable, .wrIndex, .wrData, .flagsWrEnable, .flagsWrData, .opcode, .dataWord,
    .result, .newFlags, .branchTaken, .running, .halted, .haltCode, .haltData, .ipointer
  );

  registerFile #(.RegCount(RegCount)) registerFile_i (
    .clk, .reset, .rdIndexA, .rdIndexB, .rdIndexC, .operandA, .operandB, .operandC,
    .flags, .wrEnable, .wrIndex, .wrData, .flagsWrEnable, .flagsWrData,
    .dbgIndex, .dbgValue
  );

  executeUnit executeUnit_i (
    .opcode, .operandA, .operandB, .operandC, .dataWord, .flags,
    .result, .newFlags, .branchTaken
  );

endmodule

`default_nettype wire

// ==== rtl/executeUnit.sv ====
`default_nettype none

module executeUnit (
  input  wire isaPkg::opcodeT           opcode,
  input  wire [31:0]                    operandA,
  input  wire [31:0]                    operandB,
  input  wire [31:0]                    operandC,
  input  wire [31:0]                    dataWord,
  input  wire [31:0]                    flags,
  output logic [31:0]                   result,
  output logic [isaPkg::FlagCount-1:0]  newFlags,
  output logic                          branchTaken
);

  // Register result
  always_comb begin
    case (opcode)
      isaPkg::MovRR:  result = operandB;
      isaPkg::MovRC:  result = dataWord;
      isaPkg::AddRRR: result = operandB + operandC;
      isaPkg::SubRRR: result = operandB - operandC;
      isaPkg::AddRRC: result = operandB + dataWord;
      isaPkg::ShlRRR: result = operandB << operandC;  // Zero past 31
      isaPkg::ShrRRR: result = operandB >> operandC;  // Logical
      default:        result = '0;
    endcase
  end

  // Unsigned compare of ra against rb
  always_comb begin
    newFlags = '0;
    newFlags[isaPkg::FlagEqual] = operandA == operandB;
    newFlags[isaPkg::FlagLess] = operandA < operandB;
    newFlags[isaPkg::FlagGreater] = operandA > operandB;
  end

  // Conditional jumps only, JmpC handled by the sequencer
  always_comb begin
    case (opcode)
      isaPkg::JeC:  branchTaken = flags[isaPkg::FlagEqual];
      isaPkg::JneC: branchTaken = !flags[isaPkg::FlagEqual];
      isaPkg::JzRC: branchTaken = operandA == '0;
      default:      branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/instrSequencer.sv ====
`default_nettype none

module instrSequencer #(
  parameter int RegCount = 16
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            start,
  input  wire [31:0]                     startAddress,
  output busPkg::memReqT                 memReq,
  input  wire busPkg::memRspT            memRsp,
  output logic [$clog2(RegCount)-1:0]    rdIndexA,
  output logic [$clog2(RegCount)-1:0]    rdIndexB,
  output logic [$clog2(RegCount)-1:0]    rdIndexC,
  input  wire [31:0]                     operandA,
  input  wire [31:0]                     operandB,
  input  wire [31:0]                     operandC,
  input  wire [31:0]                     flags,
  output logic                           wrEnable,
  output logic [$clog2(RegCount)-1:0]    wrIndex,
  output logic [31:0]                    wrData,
  output logic                           flagsWrEnable,
  output logic [31:0]                    flagsWrData,
  output isaPkg::opcodeT                 opcode,
  output logic [31:0]                    dataWord,
  input  wire [31:0]                     result,
  input  wire [isaPkg::FlagCount-1:0]    newFlags,
  input  wire                            branchTaken,
  output logic                           running,
  output logic                           halted,
  output isaPkg::haltCodeT               haltCode,
  output logic [31:0]                    haltData,
  output logic [31:0]                    ipointer
);

  localparam int IdxW = $clog2(RegCount);

  typedef enum logic [2:0] {
    Idle, FetchWait, Decode, DataWait, MemRequest, MemWait, Writeback, ErrorHalt
  } seqStateT;

  seqStateT          state;
  isaPkg::instrWordT instr;
  logic [31:0]       loadData;
  logic [31:0]       nextIp;
  logic [31:0]       reqAddress, reqWriteData;
  logic              reqRead, reqWrite;
  logic              rspReady, rspError;
  logic              validOp, writesReg;

  assign memReq = '{read: reqRead, write: reqWrite, address: reqAddress,
                    writeData: reqWriteData};
  assign rspReady = memRsp.status == busPkg::MemReady;
  assign rspError = memRsp.status == busPkg::MemError;

  assign opcode = isaPkg::opcodeT'(instr.opcode);  // May hold an invalid code
  assign rdIndexA = instr.regA[IdxW-1:0];  // Modulo register count
  assign rdIndexB = instr.regB[IdxW-1:0];
  assign rdIndexC = instr.regC[IdxW-1:0];
  assign validOp = instr.opcode != 8'h00 && instr.opcode <= isaPkg::MaxOpCode;

  always_comb begin
    case (opcode)
      isaPkg::MovRR, isaPkg::MovRC, isaPkg::AddRRR, isaPkg::AddRRC,
      isaPkg::SubRRR, isaPkg::ShlRRR, isaPkg::ShrRRR, isaPkg::MovRdC: writesReg = 1'b1;
      default: writesReg = 1'b0;
    endcase
  end

  // Register writes only in writeback
  assign wrEnable = state == Writeback && writesReg;
  assign wrIndex = rdIndexA;
  assign wrData = (opcode == isaPkg::MovRdC) ? loadData : result;
  assign flagsWrEnable = state == Writeback && opcode == isaPkg::CmpRR;
  assign flagsWrData = {flags[31:isaPkg::FlagCount], newFlags};  // Upper bits kept

  always_comb begin
    if (opcode == isaPkg::JmpC || branchTaken) nextIp = dataWord;
    else if (isaPkg::isTwoWord(opcode)) nextIp = ipointer + 32'd8;
    else nextIp = ipointer + 32'd4;
  end

  assign running = state != Idle && state != ErrorHalt;
  assign halted = state == ErrorHalt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= Idle;
      reqRead <= 1'b0;
      reqWrite <= 1'b0;
      ipointer <= '0;
      haltCode <= isaPkg::HaltNone;
    end else begin
      reqRead <= 1'b0;  // Strobes last one cycle
      reqWrite <= 1'b0;
      case (state)
        Idle, ErrorHalt: if (start) begin
          ipointer <= startAddress;
          haltCode <= isaPkg::HaltNone;
          reqRead <= 1'b1;
          state <= FetchWait;
        end
        FetchWait: begin
          if (rspReady) state <= Decode;
          else if (rspError) begin
            haltCode <= isaPkg::HaltBadInstr1;
            state <= ErrorHalt;
          end
        end
        Decode: begin
          if (isaPkg::isTwoWord(opcode)) begin
            reqRead <= 1'b1;  // Data word at ip + 4
            state <= DataWait;
          end else begin
            state <= Writeback;  // Operands settle this cycle
          end
        end
        DataWait: begin
          if (rspReady) state <= isaPkg::isMemOp(opcode) ? MemRequest : Writeback;
          else if (rspError) begin
            haltCode <= isaPkg::HaltBadInstr2;
            state <= ErrorHalt;
          end
        end
        MemRequest: begin
          reqRead <= opcode == isaPkg::MovRdC;
          reqWrite <= opcode == isaPkg::MovdCR;
          state <= MemWait;
        end
        MemWait: begin
          if (rspReady) state <= Writeback;
          else if (rspError) begin
            haltCode <= isaPkg::HaltBadMem;
            state <= ErrorHalt;
          end
        end
        Writeback: begin
          if (validOp) begin
            ipointer <= nextIp;
            reqRead <= 1'b1;  // Next fetch right away
            state <= FetchWait;
          end else begin
            haltCode <= isaPkg::HaltBadOpcode;  // ip stays on the bad opcode
            state <= ErrorHalt;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Address, data and captured words
  always_ff @(posedge clk) begin
    case (state)
      Idle, ErrorHalt: if (start) reqAddress <= startAddress;
      FetchWait: begin
        if (rspReady) instr <= memRsp.readData;
        if (rspError) haltData <= reqAddress;  // Faulting address
      end
      Decode: reqAddress <= ipointer + 32'd4;
      DataWait: begin
        if (rspReady) dataWord <= memRsp.readData;
        if (rspError) haltData <= reqAddress;
      end
      MemRequest: begin
        reqAddress <= dataWord;  // Absolute address
        reqWriteData <= operandB;
      end
      MemWait: begin
        if (rspReady) loadData <= memRsp.readData;
        if (rspError) haltData <= reqAddress;
      end
      Writeback: begin
        if (validOp) reqAddress <= nextIp;
        else haltData <= {24'b0, instr.opcode};
      end
      default: ;
    endcase
  end

  noReadWithWrite: assert property (@(posedge clk) disable iff (reset)
    !(memReq.read && memReq.write));
  wordAligned: assert property (@(posedge clk) disable iff (reset)
    (memReq.read || memReq.write) |-> memReq.address[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== rtl/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Encoding 0 is never valid and ends a program through the error halt
  typedef enum logic [7:0] {
    Invalid = 8'h00,
    MovRR   = 8'h01,  // ra = rb
    MovRC   = 8'h02,  // ra = const
    AddRRR  = 8'h03,  // ra = rb + rc
    AddRRC  = 8'h04,  // ra = rb + const
    SubRRR  = 8'h05,  // ra = rb - rc
    ShlRRR  = 8'h06,
    ShrRRR  = 8'h07,
    CmpRR   = 8'h08,  // Flags from ra vs rb
    MovRdC  = 8'h09,  // ra = [const]
    MovdCR  = 8'h0a,  // [const] = rb
    JmpC    = 8'h0b,
    JeC     = 8'h0c,
    JneC    = 8'h0d,
    JzRC    = 8'h0e   // Jump if ra is zero
  } opcodeT;

  localparam logic [7:0] MaxOpCode = JzRC;

  // One instruction word, opcode in the low byte
  typedef struct packed {
    logic [7:0] regC;
    logic [7:0] regB;
    logic [7:0] regA;
    logic [7:0] opcode;
  } instrWordT;

  localparam int FlagsReg = 1;  // Only special register
  localparam int FlagEqual = 0;
  localparam int FlagLess = 1;
  localparam int FlagGreater = 2;
  localparam int FlagCount = 3;

  // Five codes, so three bits
  typedef enum logic [2:0] {
    HaltNone,
    HaltBadInstr1,  // Fault on first instruction word
    HaltBadInstr2,  // Fault on data word
    HaltBadMem,
    HaltBadOpcode
  } haltCodeT;

  // Opcodes carrying a second data word
  function automatic logic isTwoWord(opcodeT op);
    case (op)
      MovRC, AddRRC, MovRdC, MovdCR, JmpC, JeC, JneC, JzRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Opcodes with a data memory access
  function automatic logic isMemOp(opcodeT op);
    return op == MovRdC || op == MovdCR;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/registerFile.sv ====
`default_nettype none

module registerFile #(
  parameter int RegCount = 16
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire [$clog2(RegCount)-1:0]  rdIndexA,
  input  wire [$clog2(RegCount)-1:0]  rdIndexB,
  input  wire [$clog2(RegCount)-1:0]  rdIndexC,
  output logic [31:0]                 operandA,
  output logic [31:0]                 operandB,
  output logic [31:0]                 operandC,
  output logic [31:0]                 flags,
  input  wire                         wrEnable,
  input  wire [$clog2(RegCount)-1:0]  wrIndex,
  input  wire [31:0]                  wrData,
  input  wire                         flagsWrEnable,
  input  wire [31:0]                  flagsWrData,
  input  wire [$clog2(RegCount)-1:0]  dbgIndex,
  output logic [31:0]                 dbgValue
);

  logic [31:0] regs [RegCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (flagsWrEnable) regs[isaPkg::FlagsReg] <= flagsWrData;
      if (wrEnable) regs[wrIndex] <= wrData;  // Wins over the flags write
    end
  end

  // Combinational reads
  assign operandA = regs[rdIndexA];
  assign operandB = regs[rdIndexB];
  assign operandC = regs[rdIndexC];
  assign flags = regs[isaPkg::FlagsReg];
  assign dbgValue = regs[dbgIndex];  // APB debug window

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f sources.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
  exit 1
fi
grep -q "Test completed successfully" sim.log

// ==== sources.f ====
rtl/isaPkg.sv
rtl/busPkg.sv
rtl/cpuControlRegs.sv
rtl/instrSequencer.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/cpuCore.sv
verification/memoryModel.sv
verification/cpuCoreTb.sv

// ==== verification/cpuCoreTb.sv ====
`default_nettype none

module cpuCoreTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RegCount = 16;
  localparam int Words = 4096;
  localparam int NumTests = 6;
  localparam int MaxInstr = 40;  // Upper bound per program
  localparam int Period = 4;
  localparam logic [31:0] ErrBase = 32'h0000_3000;
  localparam logic [31:0] ErrSize = 32'h0000_0100;

  logic           clk;
  logic           reset;
  busPkg::apbReqT apbReq;
  logic [31:0]    prdata;
  logic           pready, pslverr;
  busPkg::memReqT memReq;
  busPkg::memRspT memRsp;

  cpuCore #(.RegCount(RegCount)) cpuCore_i (
    .clk, .reset, .apbReq, .prdata, .pready, .pslverr, .memReq, .memRsp
  );

  memoryModel #(.Words(Words), .ErrBase(ErrBase), .ErrSize(ErrSize)) memoryModel_i (
    .clk, .reset, .memReq, .memRsp
  );

  // Reference state
  logic [31:0] refMem [Words];
  logic [31:0] refRegs [RegCount];
  logic [31:0] refWrAddr [$];
  logic [31:0] refWrData [$];
  logic [31:0] refIp, refHaltData;
  logic [2:0]  refHaltCode;
  logic [31:0] pc;  // Program emit pointer
  int          seed;
  int          errors, testStartErrors, passed, failed;

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  // Watchdog sized from the longest possible run
  initial begin
    #(Period * 200 * MaxInstr * NumTests);
    $display("Timeout: the core never reached its halt state in time");
    $display("Test failed");
    $finish;
  end

  function automatic logic inWindow(input logic [31:0] addr);
    return addr >= ErrBase && addr < ErrBase + ErrSize;
  endfunction

  function automatic int widx(input logic [31:0] addr);
    return int'(addr[13:2]);
  endfunction

  function automatic logic [31:0] randWord();
    return $random(seed);
  endfunction

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expectTrue(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      errors++;
    end
  endtask

  // Setup then access phase, no wait states
  task automatic apbAccess(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apbReq.penable = 1'b1;
    #2;
    rdata = prdata;  // Stable mid access cycle
    err = pslverr;
    compareValue("pready", {31'b0, pready}, 32'd1);  // Never a wait state
    @(posedge clk);
    #1;
    apbReq = '0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apbAccess(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apbAccess(1'b0, addr, '0, data, err);
  endtask

  // Same word into DUT memory and reference
  task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
    refMem[widx(addr)] = data;
    memoryModel_i.mem[widx(addr)] = data;
  endtask

  task automatic emitInstr(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b,
                           input logic [7:0] c);
    writeWord(pc, {c, b, a, op});
    pc += 4;
  endtask

  task automatic emitTwo(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b,
                         input logic [31:0] d);
    emitInstr(op, a, b, 8'h00);
    writeWord(pc, d);
    pc += 4;
  endtask

  task automatic setReg(input int idx, input logic [31:0] v);
    refRegs[idx] = v;
  endtask

  // Instruction set rules, one instruction per step
  task automatic runModel(input logic [31:0] startAddr);
    logic [31:0] ip, w, d, a, b, c, nextIp;
    logic [7:0]  op;
    logic        two, done;
    int          ra, rb, rc, steps;
    ip = startAddr;
    done = 1'b0;
    steps = 0;
    while (!done && steps < MaxInstr * 4) begin
      steps++;
      w = refMem[widx(ip)];
      op = w[7:0];
      ra = int'(w[15:8]) % RegCount;
      rb = int'(w[23:16]) % RegCount;
      rc = int'(w[31:24]) % RegCount;
      a = refRegs[ra];
      b = refRegs[rb];
      c = refRegs[rc];
      two = op inside {8'h02, 8'h04, [8'h09:8'h0e]};
      d = refMem[widx(ip + 4)];
      nextIp = ip + (two ? 32'd8 : 32'd4);
      if (inWindow(ip)) begin
        refHaltCode = isaPkg::HaltBadInstr1;
        refHaltData = ip;
        done = 1'b1;
      end else if (two && inWindow(ip + 4)) begin
        refHaltCode = isaPkg::HaltBadInstr2;
        refHaltData = ip + 4;
        done = 1'b1;
      end else begin
        case (op)
          isaPkg::MovRR:  setReg(ra, b);
          isaPkg::MovRC:  setReg(ra, d);
          isaPkg::AddRRR: setReg(ra, b + c);
          isaPkg::AddRRC: setReg(ra, b + d);
          isaPkg::SubRRR: setReg(ra, b - c);
          isaPkg::ShlRRR: setReg(ra, (c > 31) ? 32'd0 : b << c[4:0]);
          isaPkg::ShrRRR: setReg(ra, (c > 31) ? 32'd0 : b >> c[4:0]);
          isaPkg::CmpRR:  refRegs[isaPkg::FlagsReg][2:0] = {a > b, a < b, a == b};
          isaPkg::MovRdC, isaPkg::MovdCR: begin
            if (inWindow(d)) begin
              refHaltCode = isaPkg::HaltBadMem;
              refHaltData = d;
              done = 1'b1;
            end else if (op == isaPkg::MovRdC) begin
              setReg(ra, refMem[widx(d)]);
            end else begin
              refMem[widx(d)] = b;
              refWrAddr.push_back(d);
              refWrData.push_back(b);
            end
          end
          isaPkg::JmpC: nextIp = d;
          isaPkg::JeC:  if (refRegs[isaPkg::FlagsReg][0]) nextIp = d;
          isaPkg::JneC: if (!refRegs[isaPkg::FlagsReg][0]) nextIp = d;
          isaPkg::JzRC: if (a == 0) nextIp = d;
          default: begin
            refHaltCode = isaPkg::HaltBadOpcode;  // Stays on the bad word
            refHaltData = {24'b0, op};
            done = 1'b1;
          end
        endcase
      end
      if (!done) ip = nextIp;
    end
    refIp = ip;
  endtask

  // Start the core, wait for halt, compare all visible state
  task automatic runProgram(input logic [31:0] startAddr);
    logic [31:0] v;
    logic        err;
    int          logStart;
    logStart = memoryModel_i.wrAddrLog.size();
    refWrAddr.delete();
    refWrData.delete();
    runModel(startAddr);
    apbWrite(busPkg::RegStart, startAddr, err);
    apbWrite(busPkg::RegCtrl, 32'd1, err);
    do apbRead(busPkg::RegStatus, v, err); while (!v[1]);
    compareValue("status.running", {31'b0, v[0]}, 32'd0);
    compareValue("status.haltCode", {29'b0, v[4:2]}, {29'b0, refHaltCode});
    apbRead(busPkg::RegErrData, v, err);
    compareValue("haltData", v, refHaltData);
    apbRead(busPkg::RegIp, v, err);
    compareValue("ipointer", v, refIp);
    apbRead(busPkg::RegCtrl, v, err);
    compareValue("ctrl.run", v, 32'd0);  // Cleared on halt
    for (int i = 0; i < RegCount; i++) begin
      apbWrite(busPkg::RegDbgSel, i, err);
      apbRead(busPkg::RegDbgData, v, err);
      compareValue($sformatf("reg[%0d]", i), v, refRegs[i]);
    end
    compareValue("writeCount", memoryModel_i.wrAddrLog.size() - logStart, refWrAddr.size());
    for (int i = 0; i < refWrAddr.size() && logStart + i < memoryModel_i.wrAddrLog.size();
         i++) begin
      compareValue("memReq.address", memoryModel_i.wrAddrLog[logStart + i], refWrAddr[i]);
      compareValue("memReq.writeData", memoryModel_i.wrDataLog[logStart + i], refWrData[i]);
    end
  endtask

  task automatic finishTest(input string name);
    if (errors == testStartErrors) begin
      passed++;
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - testStartErrors);
    end
    testStartErrors = errors;
  endtask

  task automatic checkApbRegs();
    logic [31:0] v, addr;
    logic        err;
    apbRead(busPkg::RegStatus, v, err);
    compareValue("status after reset", v & 32'h3, 32'd0);
    addr = randWord() & 32'hffff_fffc;
    apbWrite(busPkg::RegStart, addr, err);
    apbRead(busPkg::RegStart, v, err);
    compareValue("startAddress", v, addr);
    compareValue("pslverr", {31'b0, err}, 32'd0);  // Mapped read is clean
    apbRead(8'h40, v, err);
    expectTrue(err, "read of an unmapped offset gave no slave error");
    apbWrite(busPkg::RegStatus, 32'hffff_ffff, err);
    expectTrue(err, "write to the read-only status register gave no slave error");
    finishTest("apb registers");
  endtask

  task automatic aluProgram();
    logic [7:0]  ops [6];
    logic [7:0]  op;
    logic [31:0] startAddr, w;
    ops = '{isaPkg::AddRRR, isaPkg::SubRRR, isaPkg::AddRRC, isaPkg::ShlRRR,
            isaPkg::ShrRRR, isaPkg::MovRR};
    startAddr = 32'h400 + randBelow(64) * 4;
    pc = startAddr;
    for (int r = 0; r < RegCount; r++) begin
      emitTwo(isaPkg::MovRC, r, 8'h00, (r % 2) ? randWord() : randWord() & 32'h1f);
    end
    repeat (20) begin
      op = ops[randBelow(6)];
      w = randWord();  // Modulo fields
      if (op == isaPkg::AddRRC) emitTwo(op, w[7:0], w[15:8], randWord());
      else emitInstr(op, w[7:0], w[15:8], w[23:16]);
    end
    emitInstr(8'h00, 8'h00, 8'h00, 8'h00);
    runProgram(startAddr);
    finishTest("alu program");
  endtask

  task automatic loadStoreProgram();
    logic [31:0] startAddr;
    startAddr = 32'h800;
    pc = startAddr;
    for (int r = 2; r < 8; r++) begin
      emitTwo(isaPkg::MovRdC, r, 8'h00, 32'h1000 + randBelow(1024) * 4);
    end
    emitInstr(isaPkg::AddRRR, 8, 2, 3);
    emitInstr(isaPkg::SubRRR, 9, 4, 5);
    emitInstr(isaPkg::AddRRR, 10, 6, 7);
    for (int r = 8; r < 12; r++) begin
      emitTwo(isaPkg::MovdCR, 8'h00, r, 32'h1000 + randBelow(1024) * 4);
    end
    emitInstr(8'h00, 8'h00, 8'h00, 8'h00);
    runProgram(startAddr);
    finishTest("loads and stores");
  endtask

  // Each jump skips one marker store of 8 bytes
  task automatic branchProgram();
    logic [31:0] startAddr, x;
    startAddr = 32'hc00;
    pc = startAddr;
    x = randWord();
    emitTwo(isaPkg::MovRC, 2, 8'h00, x);
    emitTwo(isaPkg::MovRC, 3, 8'h00, randBelow(2) ? x : x ^ 32'h10);
    emitInstr(isaPkg::CmpRR, 2, 3, 8'h00);
    emitTwo(isaPkg::JeC, 8'h00, 8'h00, pc + 16);
    emitTwo(isaPkg::MovdCR, 8'h00, 2, 32'h1f00);
    emitTwo(isaPkg::JneC, 8'h00, 8'h00, pc + 16);
    emitTwo(isaPkg::MovdCR, 8'h00, 3, 32'h1f04);
    emitTwo(isaPkg::MovRC, 4, 8'h00, randBelow(2) ? 32'd0 : 32'd5);
    emitTwo(isaPkg::JzRC, 4, 8'h00, pc + 16);
    emitTwo(isaPkg::MovdCR, 8'h00, 4, 32'h1f08);
    emitTwo(isaPkg::JmpC, 8'h00, 8'h00, pc + 16);
    emitTwo(isaPkg::MovdCR, 8'h00, 2, 32'h1f0c);  // Never reached
    x = pc;
    emitInstr(8'h00, 8'h00, 8'h00, 8'h00);
    runProgram(startAddr);
    compareValue("closing address", refIp, x);
    finishTest("branches");
  endtask

  task automatic errorHalts();
    logic [31:0] addr;
    pc = 32'he00;
    emitInstr(8'h00, 8'h00, 8'h00, 8'h00);
    runProgram(32'he00);
    compareValue("expected haltCode", {29'b0, refHaltCode}, {29'b0, isaPkg::HaltBadOpcode});
    compareValue("expected haltData", refHaltData, 32'd0);
    finishTest("opcode halt");
    addr = ErrBase + randBelow(64) * 4;
    pc = 32'he40;
    emitTwo(isaPkg::MovRdC, 5, 8'h00, addr);
    emitInstr(8'h00, 8'h00, 8'h00, 8'h00);
    runProgram(32'he40);
    compareValue("expected haltCode", {29'b0, refHaltCode}, {29'b0, isaPkg::HaltBadMem});
    compareValue("expected haltData", refHaltData, addr);
    finishTest("memory error halt");
  endtask

  initial begin
    seed = 32'hfd9b_08ac;
    errors = 0;
    testStartErrors = 0;
    passed = 0;
    failed = 0;
    reset = 1'b1;
    apbReq = '0;
    for (int i = 0; i < RegCount; i++) refRegs[i] = '0;
    for (int i = 0; i < Words; i++) begin
      writeWord(i * 4, (i * 32'h9e37_79b9) ^ 32'hc3a5_0f1e);  // Whole-address fill
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    checkApbRegs();
    aluProgram();
    loadStoreProgram();
    branchProgram();
    errorHalts();
    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/memoryModel.sv ====
`default_nettype none

module memoryModel #(
  parameter int          Words   = 4096,
  parameter logic [31:0] ErrBase = 32'h0000_3000,
  parameter logic [31:0] ErrSize = 32'h0000_0100,
  parameter logic [31:0] Seed    = 32'hfd9b_08ac
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire busPkg::memReqT memReq,
  output busPkg::memRspT      memRsp
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IdxW = $clog2(Words);

  logic [31:0] mem [Words];
  logic [31:0] wrAddrLog [$];  // Every accepted write, in order
  logic [31:0] wrDataLog [$];
  int          seed;
  int          countdown;
  logic        pendingErr;
  logic [31:0] pendingData;

  function automatic logic inErrWindow(input logic [31:0] addr);
    return addr >= ErrBase && addr < ErrBase + ErrSize;
  endfunction

  initial begin
    seed = Seed;
    countdown = 0;
    pendingErr = 1'b0;
    pendingData = '0;
    memRsp = '{status: busPkg::MemIdle, readData: '0};
    forever begin
      @(posedge clk);
      #1;
      memRsp.status = busPkg::MemIdle;  // Response lasts one cycle
      if (reset) begin
        countdown = 0;
      end else if (countdown > 0) begin
        countdown--;
        if (countdown == 0) begin
          memRsp.status = pendingErr ? busPkg::MemError : busPkg::MemReady;
          memRsp.readData = pendingData;
        end
      end else if (memReq.read || memReq.write) begin
        pendingErr = inErrWindow(memReq.address);
        pendingData = mem[memReq.address[IdxW+1:2]];
        if (memReq.write && !pendingErr) begin
          mem[memReq.address[IdxW+1:2]] = memReq.writeData;
          wrAddrLog.push_back(memReq.address);
          wrDataLog.push_back(memReq.writeData);
        end
        countdown = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
      end
    end
  end

endmodule

`default_nettype wire
